//--- verification/rf_pg_cases.txt
# Columns: op addr value, addr and value in hex
# W addr data, R addr expected, B addr blocked flag, D power down, U power up
W 00 15a5a
R 00 15a5a
W 3f 1ffff
R 3f 1ffff
W 20 0c3c3
W 01 1ffff
R 20 0c3c3
# Write elsewhere while the last read is still on rdata
W 21 00001
R 01 1ffff
R 20 0c3c3
W 15 12345
R 15 12345
D
B 15 1
B 3f 1
# Down request while off is ignored
D
B 00 1
U
W 15 0abcd
R 15 0abcd
W 3f 10001
R 3f 10001
# Up request while on is ignored
U
R 15 0abcd
D
U
W 2a 1ffff
R 2a 1ffff

//--- compile.f
hdl/rf_pkg.sv
hdl/rf_reset_sync.sv
hdl/rf_array_64x18.sv
hdl/rf_pg_64x17.sv
hdl/rf_pwr_ctrl.sv
hdl/rf_pg_top.sv
verification/rf_pg_tb.sv

//--- Makefile
# Verilator build and run of the power-gated register file testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module rf_pg_tb -Mdir obj_dir -f compile.f
	./obj_dir/Vrf_pg_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/rf_pg_tb.sv
/*
 * Testbench for the power-gated register file. Loads operations and their
 * expected results from the case file, drives both ports on the falling
 * clock edge and checks data, status and blocked pulses one edge later.
 */

`timescale 1ns/1ps

module rf_pg_tb;

    localparam int reset_cycles = 10;
    localparam int ready_bound  = 8;
    localparam int pwr_bound    = 24;
    // Worst case is a full power transition plus the widest idle gap
    localparam int case_bound   = 40;
    localparam int max_cases    = 64;

    logic                         wclk;
    logic                         rclk;
    logic                         rst;
    rf_pkg::rf_wr_req_t           wr;
    rf_pkg::rf_rd_req_t           rd;
    logic                         pwr_down_req;
    logic                         pwr_up_req;
    logic [rf_pkg::rf_data_w-1:0] rdata;
    rf_pkg::rf_pwr_status_t       status;
    logic                         wr_blocked;
    logic                         rd_blocked;

    logic [7:0]                   case_op   [max_cases];
    logic [rf_pkg::rf_addr_w-1:0] case_addr [max_cases];
    logic [rf_pkg::rf_data_w-1:0] case_val  [max_cases];
    int                           n_cases;
    int                           cycle_count;
    int                           cycle_limit;

    // Reference view of what the array should be showing right now
    logic                         powered;
    logic                         rdata_known;
    logic [rf_pkg::rf_data_w-1:0] last_rdata;

    rf_pg_top #(
        .SYNC_STAGES     (2),
        .PWR_CHAIN_DELAY (4),
        .WAKE_CYCLES     (3)
    ) u_dut (
         .wclk         (wclk)
        ,.rclk         (rclk)
        ,.rst          (rst)
        ,.wr           (wr)
        ,.rd           (rd)
        ,.pwr_down_req (pwr_down_req)
        ,.pwr_up_req   (pwr_up_req)
        ,.rdata        (rdata)
        ,.status       (status)
        ,.wr_blocked   (wr_blocked)
        ,.rd_blocked   (rd_blocked)
    );

    // Both port clocks run in phase from one generator
    always begin
        #20;
        wclk = ~wclk;
        rclk = ~rclk;
    end

    always @(posedge wclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run("The run did not finish within its cycle limit");
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_data(input string name, input logic [rf_pkg::rf_data_w-1:0] got,
                              input logic [rf_pkg::rf_data_w-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_status(input string name, input rf_pkg::rf_pwr_status_t got,
                                input rf_pkg::rf_pwr_status_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic rf_pkg::rf_pwr_status_t status_val(input logic r, input logic i,
                                                          input logic o);
        rf_pkg::rf_pwr_status_t s;
        s.ready    = r;
        s.isolated = i;
        s.off      = o;
        return s;
    endfunction

    // A settled array is either fully on or fully off and isolated
    task automatic check_settled();
        if (powered) begin
            check_status("status", status, status_val(1'b1, 1'b0, 1'b0));
        end else begin
            check_status("status", status, status_val(1'b0, 1'b1, 1'b1));
        end
        check_flag("wr_blocked", wr_blocked, 1'b0);
        check_flag("rd_blocked", rd_blocked, 1'b0);
        if (!powered) begin
            check_data("rdata", rdata, '0);
        end else if (rdata_known) begin
            check_data("rdata", rdata, last_rdata);
        end
    endtask

    // ------------------------------
    // Port operations
    // ------------------------------

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge wclk);
            check_settled();
        end
    endtask

    task automatic write_entry(input logic [rf_pkg::rf_addr_w-1:0] addr,
                               input logic [rf_pkg::rf_data_w-1:0] data);
        wr.we    = 1'b1;
        wr.waddr = addr;
        wr.wdata = data;
        @(negedge wclk);
        wr.we = 1'b0;
        // The read register must not move on a write
        check_settled();
    endtask

    task automatic read_entry(input logic [rf_pkg::rf_addr_w-1:0] addr,
                              input logic [rf_pkg::rf_data_w-1:0] exp);
        rd.re    = 1'b1;
        rd.raddr = addr;
        @(negedge wclk);
        rd.re = 1'b0;
        check_data("rdata", rdata, exp);
        check_flag("rd_blocked", rd_blocked, 1'b0);
        last_rdata  = exp;
        rdata_known = 1'b1;
    endtask

    // Both ports hit the same entry at once while the array is off
    task automatic blocked_access(input logic [rf_pkg::rf_addr_w-1:0] addr, input logic flag);
        wr.we    = 1'b1;
        wr.waddr = addr;
        wr.wdata = 17'h1aaaa;
        rd.re    = 1'b1;
        rd.raddr = addr;
        @(negedge wclk);
        wr.we = 1'b0;
        rd.re = 1'b0;
        check_flag("wr_blocked", wr_blocked, flag);
        check_flag("rd_blocked", rd_blocked, flag);
        check_data("rdata", rdata, '0);
    endtask

    task automatic power_down();
        logic was_powered;
        int   waited;
        was_powered  = powered;
        pwr_down_req = 1'b1;
        @(negedge wclk);
        pwr_down_req = 1'b0;
        // Ready drops and isolation rises on the edge that takes the pulse
        if (was_powered) begin
            check_status("status", status, status_val(1'b0, 1'b1, 1'b0));
        end else begin
            check_status("status", status, status_val(1'b0, 1'b1, 1'b1));
        end
        check_data("rdata", rdata, '0);
        waited = 0;
        while (status.off !== 1'b1) begin
            if (waited >= pwr_bound) begin
                abort_run("Power down did not reach the off state in time");
            end else begin
                @(negedge wclk);
                check_flag("status.ready", status.ready, 1'b0);
                check_flag("status.isolated", status.isolated, 1'b1);
                waited++;
            end
        end
        powered = 1'b0;
        check_settled();
    endtask

    task automatic power_up();
        logic was_powered;
        int   waited;
        was_powered = powered;
        pwr_up_req  = 1'b1;
        @(negedge wclk);
        pwr_up_req = 1'b0;
        if (was_powered) begin
            check_status("status", status, status_val(1'b1, 1'b0, 1'b0));
        end else begin
            check_status("status", status, status_val(1'b0, 1'b1, 1'b1));
        end
        waited = 0;
        // Isolation stays on for the whole wake sequence
        while (status.ready !== 1'b1) begin
            if (waited >= pwr_bound) begin
                abort_run("Power up did not bring ready back in time");
            end else begin
                check_flag("status.isolated", status.isolated, 1'b1);
                check_data("rdata", rdata, '0);
                @(negedge wclk);
                waited++;
            end
        end
        powered = 1'b1;
        // Contents of a non-retentive array are unknown after a wake
        if (!was_powered) begin
            rdata_known = 1'b0;
        end
        check_status("status", status, status_val(1'b1, 1'b0, 1'b0));
    endtask

    // ------------------------------
    // Case file and sequencing
    // ------------------------------

    task automatic load_cases();
        int               fd;
        int               r;
        int               a;
        int               v;
        logic [8*8-1:0]   tok;
        logic [8*128-1:0] rest;
        fd = $fopen("verification/rf_pg_cases.txt", "r");
        if (fd == 0) begin
            abort_run("The case file could not be opened");
        end else begin
            n_cases = 0;
            r = $fscanf(fd, "%s", tok);
            while (r == 1) begin
                if (tok[7:0] == "#") begin
                    r = $fgets(rest, fd);
                end else if (n_cases >= max_cases) begin
                    abort_run("The case file holds more operations than the testbench stores");
                end else begin
                    a = 0;
                    v = 0;
                    if (tok[7:0] == "W" || tok[7:0] == "R" || tok[7:0] == "B") begin
                        r = $fscanf(fd, "%h %h", a, v);
                    end
                    case_op[n_cases]   = tok[7:0];
                    case_addr[n_cases] = a[rf_pkg::rf_addr_w-1:0];
                    case_val[n_cases]  = v[rf_pkg::rf_data_w-1:0];
                    n_cases++;
                end
                r = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        int waited;
        rst = 1'b1;
        for (int k = 1; k <= reset_cycles; k++) begin
            @(negedge wclk);
            // Read-domain flops only see rst_sync from the second edge on
            if (k >= 3) begin
                check_status("status", status, status_val(1'b0, 1'b0, 1'b0));
                check_data("rdata", rdata, '0);
                check_flag("wr_blocked", wr_blocked, 1'b0);
                check_flag("rd_blocked", rd_blocked, 1'b0);
            end
        end
        rst    = 1'b0;
        waited = 0;
        while (status.ready !== 1'b1) begin
            if (waited >= ready_bound) begin
                abort_run("Ready did not rise after reset was released");
            end else begin
                check_status("status", status, status_val(1'b0, 1'b0, 1'b0));
                @(negedge wclk);
                waited++;
            end
        end
        powered     = 1'b1;
        rdata_known = 1'b1;
        last_rdata  = '0;
        check_settled();
    endtask

    task automatic run_case(input int i);
        case (case_op[i])
            "W": write_entry(case_addr[i], case_val[i]);
            "R": read_entry(case_addr[i], case_val[i]);
            "B": blocked_access(case_addr[i], case_val[i][0]);
            "D": power_down();
            "U": power_up();
            default: abort_run("The case file holds an unknown operation");
        endcase
    endtask

    initial begin
        int gap;
        wclk         = 1'b0;
        rclk         = 1'b0;
        rst          = 1'b1;
        wr           = '0;
        rd           = '0;
        pwr_down_req = 1'b0;
        pwr_up_req   = 1'b0;
        cycle_count  = 0;
        powered      = 1'b0;
        rdata_known  = 1'b0;
        last_rdata   = '0;
        n_cases      = 0;
        cycle_limit  = reset_cycles + ready_bound + case_bound;
        void'($urandom(32'hf768db3d));
        load_cases();
        cycle_limit = reset_cycles + ready_bound + (n_cases + 1) * case_bound;
        apply_reset();
        for (int i = 0; i < n_cases; i++) begin
            // Idle gaps also check that rdata and status hold
            gap = 3 + int'($urandom % 32'd4);
            idle_cycles(gap);
            run_case(i);
        end
        idle_cycles(4);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- hdl/rf_pg_top.sv
/*
 * Top level of the power-gated register file. Joins the gating controller
 * to the 64x17 wrapper and sets the timing parameters for both.
 */

`timescale 1ns/1ps

module rf_pg_top #(
    parameter int SYNC_STAGES     = 2,
    parameter int PWR_CHAIN_DELAY = 4,
    parameter int WAKE_CYCLES     = 3
) (
     input  logic                          wclk
    ,input  logic                          rclk
    ,input  logic                          rst

    ,input  rf_pkg::rf_wr_req_t            wr
    ,input  rf_pkg::rf_rd_req_t            rd
    ,input  logic                          pwr_down_req
    ,input  logic                          pwr_up_req

    ,output logic [rf_pkg::rf_data_w-1:0]  rdata
    ,output rf_pkg::rf_pwr_status_t        status
    ,output logic                          wr_blocked
    ,output logic                          rd_blocked
);

    rf_pkg::rf_wr_req_t wr_gated;
    rf_pkg::rf_rd_req_t rd_gated;
    logic               isol_en;
    logic               pwr_enable_b;
    logic               pwr_enable_b_out;
    logic               rst_sync;

    rf_pwr_ctrl #(
        .WAKE_CYCLES (WAKE_CYCLES)
    ) u_pwr_ctrl (
         .wclk             (wclk)
        ,.rclk             (rclk)
        ,.rst              (rst)
        ,.rst_sync         (rst_sync)
        ,.wr               (wr)
        ,.rd               (rd)
        ,.pwr_down_req     (pwr_down_req)
        ,.pwr_up_req       (pwr_up_req)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.wr_gated         (wr_gated)
        ,.rd_gated         (rd_gated)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b     (pwr_enable_b)
        ,.status           (status)
        ,.wr_blocked       (wr_blocked)
        ,.rd_blocked       (rd_blocked)
    );

    // The wrapper returns the chain end as the controller's acknowledge
    rf_pg_64x17 #(
        .SYNC_STAGES     (SYNC_STAGES),
        .PWR_CHAIN_DELAY (PWR_CHAIN_DELAY)
    ) u_rf (
         .wclk             (wclk)
        ,.rclk             (rclk)
        ,.rst              (rst)
        ,.wr               (wr_gated)
        ,.rd               (rd_gated)
        ,.rdata            (rdata)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b     (pwr_enable_b)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.rst_sync         (rst_sync)
    );

endmodule

//--- hdl/rf_pwr_ctrl.sv
/*
 * Power-gating controller. Sequences isolation and the switch enable on
 * rclk, and masks write and read strobes whenever the array is not ready.
 * Dropped strobes are reported as one-cycle blocked pulses.
 */

`timescale 1ns/1ps

module rf_pwr_ctrl #(
    parameter int WAKE_CYCLES = 3
) (
     input  logic                   wclk
    ,input  logic                   rclk
    ,input  logic                   rst
    ,input  logic                   rst_sync

    ,input  rf_pkg::rf_wr_req_t     wr
    ,input  rf_pkg::rf_rd_req_t     rd
    ,input  logic                   pwr_down_req
    ,input  logic                   pwr_up_req
    ,input  logic                   pwr_enable_b_out

    ,output rf_pkg::rf_wr_req_t     wr_gated
    ,output rf_pkg::rf_rd_req_t     rd_gated
    ,output logic                   isol_en
    ,output logic                   pwr_enable_b
    ,output rf_pkg::rf_pwr_status_t status
    ,output logic                   wr_blocked
    ,output logic                   rd_blocked
);

    localparam int WAKE_W = $clog2(WAKE_CYCLES + 1);

    rf_pkg::rf_pwr_state_e state_q;
    logic [WAKE_W-1:0]     wake_cnt;
    logic                  ready_q;
    logic                  isol_q;
    logic                  pwr_en_b_q;
    logic                  off_q;
    logic [1:0]            ready_w_sync;
    logic                  ready_w;

    // ------------------------------
    // Power sequencing FSM
    // ------------------------------

    always_ff @(posedge rclk) begin
        if (rst_sync) begin
            state_q    <= rf_pkg::pwr_on;
            wake_cnt   <= '0;
            ready_q    <= 1'b0;
            isol_q     <= 1'b0;
            pwr_en_b_q <= 1'b0;
            off_q      <= 1'b0;
        end else begin
            case (state_q)
                rf_pkg::pwr_on: begin
                    // Ready comes up on the first cycle out of reset
                    if (pwr_down_req) begin
                        state_q <= rf_pkg::pwr_isolate;
                        ready_q <= 1'b0;
                        isol_q  <= 1'b1;
                    end else begin
                        ready_q <= 1'b1;
                    end
                end
                rf_pkg::pwr_isolate: begin
                    // Isolation has been up for a full cycle before switching
                    state_q    <= rf_pkg::pwr_switch_off;
                    pwr_en_b_q <= 1'b1;
                end
                rf_pkg::pwr_switch_off: begin
                    if (pwr_enable_b_out) begin
                        state_q <= rf_pkg::pwr_off;
                        off_q   <= 1'b1;
                    end
                end
                rf_pkg::pwr_off: begin
                    if (pwr_up_req) begin
                        state_q    <= rf_pkg::pwr_switch_on;
                        pwr_en_b_q <= 1'b0;
                    end
                end
                rf_pkg::pwr_switch_on: begin
                    // Wait for the end of the chain to see the enable
                    if (!pwr_enable_b_out) begin
                        state_q  <= rf_pkg::pwr_wake;
                        off_q    <= 1'b0;
                        wake_cnt <= '0;
                    end
                end
                rf_pkg::pwr_wake: begin
                    // Let the rails settle before the outputs are released
                    if (wake_cnt == WAKE_W'(WAKE_CYCLES - 1)) begin
                        state_q <= rf_pkg::pwr_on;
                        isol_q  <= 1'b0;
                        ready_q <= 1'b1;
                    end else begin
                        wake_cnt <= wake_cnt + 1'b1;
                    end
                end
                default: begin
                    state_q <= rf_pkg::pwr_on;
                end
            endcase
        end
    end

    assign isol_en      = isol_q;
    assign pwr_enable_b = pwr_en_b_q;
    assign status       = '{ready: ready_q, isolated: isol_q, off: off_q};

    // ------------------------------
    // Read port gating
    // ------------------------------

    always_comb begin
        rd_gated    = rd;
        rd_gated.re = rd.re & ready_q;
    end

    always_ff @(posedge rclk) begin
        if (rst_sync) begin
            rd_blocked <= 1'b0;
        end else begin
            rd_blocked <= rd.re & ~ready_q;
        end
    end

    // ------------------------------
    // Write port gating
    // ------------------------------

    // Ready crosses into the write domain through two flops
    always_ff @(posedge wclk) begin
        if (rst) begin
            ready_w_sync <= '0;
            wr_blocked   <= 1'b0;
        end else begin
            ready_w_sync <= {ready_w_sync[0], ready_q};
            wr_blocked   <= wr.we & ~ready_w;
        end
    end

    assign ready_w = ready_w_sync[1];

    always_comb begin
        wr_gated    = wr;
        wr_gated.we = wr.we & ready_w;
    end

    // The switch must never open on an array whose outputs are still live
    a_isol_before_off : assert property (@(posedge rclk) disable iff (rst_sync)
        pwr_enable_b |-> isol_en && $past(isol_en));

endmodule

//--- hdl/rf_pg_64x17.sv
/*
 * Logical 64x17 register file around the 18-bit physical macro. Pads the
 * write word with a zero spare bit, trims it again on read, and brings the
 * reset into the read domain for the macro.
 */

`timescale 1ns/1ps

module rf_pg_64x17 #(
    parameter int SYNC_STAGES     = 2,
    parameter int PWR_CHAIN_DELAY = 4
) (
     input  logic                          wclk
    ,input  logic                          rclk
    ,input  logic                          rst

    ,input  rf_pkg::rf_wr_req_t            wr
    ,input  rf_pkg::rf_rd_req_t            rd
    ,output logic [rf_pkg::rf_data_w-1:0]  rdata

    // Power controls from the gating controller
    ,input  logic                          isol_en
    ,input  logic                          pwr_enable_b
    ,output logic                          pwr_enable_b_out

    ,output logic                          rst_sync
);

    logic [rf_pkg::rf_phys_w-1:0] wdata_phys;
    logic [rf_pkg::rf_phys_w-1:0] rdata_phys;

    // ------------------------------
    // Reset into the read domain
    // ------------------------------

    rf_reset_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_reset_sync (
         .rclk     (rclk)
        ,.rst      (rst)
        ,.rst_sync (rst_sync)
    );

    // Spare bit is unused by the logical word and always written as zero
    assign wdata_phys = {1'b0, wr.wdata};

    rf_array_64x18 #(
        .PWR_CHAIN_DELAY (PWR_CHAIN_DELAY)
    ) u_array (
         .wclk             (wclk)
        ,.we               (wr.we)
        ,.waddr            (wr.waddr)
        ,.wdata            (wdata_phys)
        ,.rclk             (rclk)
        ,.rst              (rst_sync)
        ,.re               (rd.re)
        ,.raddr            (rd.raddr)
        ,.rdata            (rdata_phys)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // Drop the spare bit on the way out
    assign rdata = rdata_phys[rf_pkg::rf_data_w-1:0];

endmodule

//--- hdl/rf_array_64x18.sv
/*
 * Behavioural model of the two-port 64x18 macro. Storage is written on wclk
 * and read into a registered output on rclk. The power switch enable runs
 * through a delay chain, and the isolation input clamps the read data.
 */

`timescale 1ns/1ps

module rf_array_64x18 #(
    parameter int PWR_CHAIN_DELAY = 4
) (
     input  logic                          wclk
    ,input  logic                          we
    ,input  logic [rf_pkg::rf_addr_w-1:0]  waddr
    ,input  logic [rf_pkg::rf_phys_w-1:0]  wdata

    ,input  logic                          rclk
    ,input  logic                          rst
    ,input  logic                          re
    ,input  logic [rf_pkg::rf_addr_w-1:0]  raddr
    ,output logic [rf_pkg::rf_phys_w-1:0]  rdata

    ,input  logic                          isol_en
    ,input  logic                          pwr_enable_b_in
    ,output logic                          pwr_enable_b_out
);

    logic [rf_pkg::rf_phys_w-1:0] mem [rf_pkg::rf_depth];
    logic [rf_pkg::rf_phys_w-1:0] rd_q;
    logic [PWR_CHAIN_DELAY-1:0]   pwr_chain;

    // ------------------------------
    // Power switch chain
    // ------------------------------

    // Models the daisy chain of switch segments, each one clock behind the last
    always_ff @(posedge rclk) begin
        if (rst) begin
            pwr_chain <= '0;
        end else begin
            pwr_chain[0] <= pwr_enable_b_in;
            for (int i = 1; i < PWR_CHAIN_DELAY; i++) begin
                pwr_chain[i] <= pwr_chain[i-1];
            end
        end
    end

    // The last segment reports that the whole array is switched
    assign pwr_enable_b_out = pwr_chain[PWR_CHAIN_DELAY-1];

    // ------------------------------
    // Storage and read register
    // ------------------------------

    // An unpowered array cannot store anything
    always_ff @(posedge wclk) begin
        if (we && !pwr_enable_b_out) begin
            mem[waddr] <= wdata;
        end
    end

    // Read data holds until the next accepted read
    always_ff @(posedge rclk) begin
        if (rst) begin
            rd_q <= '0;
        end else if (re && !pwr_enable_b_out) begin
            rd_q <= mem[raddr];
        end
    end

    // Isolation clamps the outputs so a floating array never leaks out
    assign rdata = isol_en ? '0 : rd_q;

    // The controller has to hold off both ports while the chain reports off
    a_no_read_off : assert property (@(posedge rclk) disable iff (rst)
        pwr_enable_b_out |-> !re);

    a_no_write_off : assert property (@(posedge wclk) disable iff (rst)
        pwr_enable_b_out |-> !we);

endmodule

//--- hdl/rf_reset_sync.sv
/*
 * Carries the active-high reset into the read clock domain. The output
 * asserts with rst and releases SYNC_STAGES read clocks after it drops.
 */

`timescale 1ns/1ps

module rf_reset_sync #(
    parameter int SYNC_STAGES = 2
) (
     input  logic rclk
    ,input  logic rst
    ,output logic rst_sync
);

    // Each stage is set by reset and then drains toward zero one per clock
    logic [SYNC_STAGES-1:0] sync_q;

    always_ff @(posedge rclk) begin
        if (rst) begin
            sync_q <= '1;
        end else begin
            sync_q <= sync_q << 1;
        end
    end

    // The oldest stage is the read-domain reset
    assign rst_sync = sync_q[SYNC_STAGES-1];

    // Release must take the full depth of the chain after reset drops
    a_rst_sync_hold : assert property (@(posedge rclk)
        $fell(rst) |-> rst_sync [*SYNC_STAGES]);

endmodule

//--- hdl/rf_pkg.sv
/*
 * Shared widths, port request structs and power state encoding for the
 * power-gated 64x17 register file. Modules refer to these by scoped name.
 */

package rf_pkg;

    // ------------------------------
    // Array geometry
    // ------------------------------

    // Six address bits select one of 64 entries
    localparam int rf_addr_w = 6;
    localparam int rf_data_w = 17;
    // The physical macro carries one spare bit above the logical word
    localparam int rf_phys_w = 18;
    localparam int rf_depth  = 1 << rf_addr_w;

    // ------------------------------
    // Port requests
    // ------------------------------

    // The write port request is 24 bits wide with the strobe on top
    typedef struct packed {
        logic                 we;
        logic [rf_addr_w-1:0] waddr;
        logic [rf_data_w-1:0] wdata;
    } rf_wr_req_t;

    // The read port request is 7 bits wide
    typedef struct packed {
        logic                 re;
        logic [rf_addr_w-1:0] raddr;
    } rf_rd_req_t;

    // A full off/on cycle walks the power states in the listed order
    typedef enum logic [2:0] {
        pwr_on,
        pwr_isolate,
        pwr_switch_off,
        pwr_off,
        pwr_switch_on,
        pwr_wake
    } rf_pwr_state_e;

    // Status flags reported to the system
    typedef struct packed {
        logic ready;
        logic isolated;
        logic off;
    } rf_pwr_status_t;

endpackage
